// ==== bench/lsuHandshake_props.sv ====
`default_nettype none

module lsuHandshakeProps (
    input wire logic clk,
    input wire logic rst,
    input wire logic memReq,
    input wire logic memAck,
    input wire logic doneValid
);

    timeunit 1ns;
    timeprecision 100ps;

    // the request is held until the controller answers.
    reqHeldUntilAck: assert property (
        @(posedge clk) disable iff (rst) (memReq && !memAck) |=> memReq
    ) else $error("memReq dropped before memAck arrived");

    ackNeedsReq: assert property (
        @(posedge clk) disable iff (rst) $rose(memAck) |-> memReq
    ) else $error("memAck rose without memReq");

    reqWaitsForRelease: assert property (
        @(posedge clk) disable iff (rst) $rose(memReq) |-> !memAck
    ) else $error("memReq rose while memAck was still high");

    donePulseSingle: assert property (
        @(posedge clk) disable iff (rst) doneValid |=> !doneValid
    ) else $error("doneValid lasted more than one cycle");

endmodule

bind dataAccessPort lsuHandshakeProps handshakeProps (
    .clk       (clk),
    .rst       (rst),
    .memReq    (memReq),
    .memAck    (memAck),
    .doneValid (doneValid)
);

`default_nettype wire

// ==== bench/lsuTb.sv ====
`default_nettype none

module lsuTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ClkPeriod = 100;
    localparam int TotalRequests = 60;
    localparam int DrainLimit = 200;

    logic clk;
    logic rst;

    logic reqValid;
    logic reqStore;
    lsuPkg::addr_t reqAddr;
    lsuPkg::data_t reqData;
    lsuPkg::accessLen_t reqLen;
    lsuPkg::tag_t reqTag;
    logic reqReady;

    logic doneValid;
    lsuPkg::data_t doneData;
    lsuPkg::tag_t doneTag;

    lsuPkg::memByte_t model [lsuPkg::MemBytes]; // reference copy of the RAM contents.
    lsuPkg::tag_t expTags[$];
    lsuPkg::data_t expData[$];

    lsuPkg::tag_t nextTag;
    logic [31:0] lcgState;
    int errorCount;
    int checkCount;
    int stallCycles;

    lsuTop DUT (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (reqValid),
        .reqStore  (reqStore),
        .reqAddr   (reqAddr),
        .reqData   (reqData),
        .reqLen    (reqLen),
        .reqTag    (reqTag),
        .reqReady  (reqReady),
        .doneValid (doneValid),
        .doneData  (doneData),
        .doneTag   (doneTag)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic int accessBytes(input lsuPkg::accessLen_t len);
        int n;
        case (len)
            lsuPkg::LenByte: n = 1;
            lsuPkg::LenHalf: n = 2;
            default: n = 4;
        endcase
        return n;
    endfunction

    // called on a falling edge; returns on the falling edge after the transfer.
    task automatic sendRequest(input logic store, input lsuPkg::addr_t addr,
                               input lsuPkg::data_t data, input lsuPkg::accessLen_t len);
        lsuPkg::data_t expValue;
        lsuPkg::memAddr_t byteAddr;
        int n;
        int i;
        expValue = '0;
        n = accessBytes(len);
        reqValid = 1'b1;
        reqStore = store;
        reqAddr = addr;
        reqData = data;
        reqLen = len;
        reqTag = nextTag;
        while (!reqReady) begin
            stallCycles++;
            @(negedge clk);
        end
        for (i = 0; i < n; i++) begin
            byteAddr = lsuPkg::memAddr_t'(addr + i); // wraps inside the RAM.
            if (store) begin
                model[byteAddr] = data[8*i +: 8];
            end else begin
                expValue[8*i +: 8] = model[byteAddr];
            end
        end
        expTags.push_back(nextTag);
        expData.push_back(expValue);
        nextTag++;
        @(negedge clk);
        reqValid = 1'b0;
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (expTags.size() != 0 && cycles < DrainLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (expTags.size() != 0) begin
            errorCount++;
            $display("At time %0t %0d completions never arrived", $time, expTags.size());
            expTags.delete();
            expData.delete();
        end
    endtask

    task automatic testResetState();
        int i;
        if (reqReady !== 1'b1) begin
            errorCount++;
            $display("Mismatch at %0t: reqReady is not high after reset", $time);
        end
        for (i = 0; i < 6; i++) begin
            @(negedge clk);
            if (doneValid !== 1'b0) begin
                errorCount++;
                $display("Mismatch at %0t: doneValid is active with no request", $time);
            end
        end
    endtask

    task automatic testWordRoundTrip();
        sendRequest(1'b1, 32'h0000_0100, 32'ha5c3_1e7f, lsuPkg::LenWord);
        sendRequest(1'b0, 32'h0000_0100, 32'hffff_ffff, lsuPkg::LenWord);
        waitDrain();
    endtask

    task automatic testSubwordAccess();
        sendRequest(1'b1, 32'h0000_0040, 32'h4433_2211, lsuPkg::LenWord);
        sendRequest(1'b1, 32'h0000_0041, 32'hdead_beab, lsuPkg::LenByte); // upper bytes ignored.
        sendRequest(1'b1, 32'h0000_0042, 32'h1234_cdef, lsuPkg::LenHalf);
        sendRequest(1'b0, 32'h0000_0041, 32'h0, lsuPkg::LenByte);
        sendRequest(1'b0, 32'h0000_0042, 32'h0, lsuPkg::LenHalf);
        sendRequest(1'b0, 32'h0000_0040, 32'h0, lsuPkg::LenWord);
        sendRequest(1'b0, 32'h0000_1443, 32'h0, lsuPkg::LenByte); // aliases byte 0x043.
        waitDrain();
    endtask

    task automatic testQueueFull();
        stallCycles = 0;
        sendRequest(1'b1, 32'h0000_0200, 32'h0102_0304, lsuPkg::LenWord);
        sendRequest(1'b1, 32'h0000_0204, 32'h1122_3344, lsuPkg::LenWord);
        sendRequest(1'b1, 32'h0000_0208, 32'h5566_7788, lsuPkg::LenWord);
        sendRequest(1'b1, 32'h0000_020c, 32'h99aa_bbcc, lsuPkg::LenWord);
        sendRequest(1'b0, 32'h0000_0204, 32'h0, lsuPkg::LenWord);
        if (stallCycles != 0) begin
            errorCount++;
            $display("Mismatch at %0t: reqReady fell before the queue was full", $time);
        end
        sendRequest(1'b0, 32'h0000_020a, 32'h0, lsuPkg::LenHalf); // this one has to wait.
        if (stallCycles == 0) begin
            errorCount++;
            $display("Mismatch at %0t: reqReady stayed high with the queue full", $time);
        end
        waitDrain();
    endtask

    task automatic testRandomTraffic();
        logic [31:0] r;
        lsuPkg::addr_t addr;
        lsuPkg::accessLen_t len;
        int i;
        // the window spans the top of the RAM and wraps to its bottom.
        for (i = 0; i < 5; i++) begin
            sendRequest(1'b1, 32'h0000_03f8 + 4 * i, nextRandom(), lsuPkg::LenWord);
        end
        for (i = 0; i < 40; i++) begin
            r = nextRandom();
            addr = 32'h0000_03f8 + r[23:20] + (r[24] ? 32'h0000_0400 : 32'h0);
            case (r[18:17])
                2'd0: len = lsuPkg::LenByte;
                2'd1: len = lsuPkg::LenHalf;
                default: len = lsuPkg::LenWord;
            endcase
            sendRequest(r[16], addr, nextRandom(), len);
        end
        waitDrain();
    endtask

    // compares each completion pulse with the oldest outstanding request.
    initial begin
        lsuPkg::tag_t wantTag;
        lsuPkg::data_t wantData;
        forever begin
            @(negedge clk);
            if (doneValid === 1'b1) begin
                checkCount++;
                if (expTags.size() == 0) begin
                    errorCount++;
                    $display("At time %0t a completion came out with no request pending", $time);
                end else begin
                    wantTag = expTags.pop_front();
                    wantData = expData.pop_front();
                    if (doneTag !== wantTag || doneData !== wantData) begin
                        errorCount++;
                        $display("Mismatch at %0t: tag %0d data %h, expected tag %0d data %h",
                                 $time, doneTag, doneData, wantTag, wantData);
                    end
                end
            end
        end
    end

    initial begin
        #((TotalRequests * 20 + 8 + 100) * ClkPeriod);
        $display("Timeout: the run did not finish in time, %0d errors so far", errorCount);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        reqValid = 1'b0;
        reqStore = 1'b0;
        reqAddr = '0;
        reqData = '0;
        reqLen = lsuPkg::LenByte;
        reqTag = '0;
        nextTag = '0;
        lcgState = 32'h25c9;
        errorCount = 0;
        checkCount = 0;
        stallCycles = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        testResetState();
        testWordRoundTrip();
        testSubwordAccess();
        testQueueFull();
        testRandomTraffic();

        repeat (5) @(negedge clk); // late stray pulses still get flagged.
        $display("Summary: %0d completions checked, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/lsuPkg.sv
verilog/loadStoreQueue.sv
verilog/dataAccessPort.sv
verilog/memController.sv
verilog/lsuTop.sv
bench/lsuHandshake_props.sv
bench/lsuTb.sv

// ==== verilog/dataAccessPort.sv ====
`default_nettype none

module dataAccessPort (
    input  logic               clk,
    input  logic               rst,

    input  logic               issueValid,
    input  logic               issueStore,
    input  lsuPkg::addr_t      issueAddr,
    input  lsuPkg::data_t      issueData,
    input  lsuPkg::accessLen_t issueLen,
    input  lsuPkg::tag_t       issueTag,
    output logic               portFree,

    output logic               memReq,
    output logic               memStore,
    output lsuPkg::addr_t      memAddr,
    output lsuPkg::data_t      memWdata,
    output lsuPkg::accessLen_t memLen,
    input  logic               memAck,
    input  lsuPkg::data_t      memRdata,

    output logic               doneValid,
    output lsuPkg::data_t      doneData,
    output lsuPkg::tag_t       doneTag
);

    typedef enum logic [1:0] {
        Idle,
        Request,
        WaitRelease
    } portState_t;

    portState_t state;
    logic occupied;
    logic transfer;
    lsuPkg::tag_t savedTag;

    assign portFree = !occupied;
    assign transfer = issueValid && portFree;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            occupied <= 1'b0;
            memReq <= 1'b0;
            doneValid <= 1'b0;
        end else begin
            doneValid <= 1'b0;
            if (transfer) begin
                occupied <= 1'b1;
            end
            case (state)
                Idle: begin
                    if (transfer) begin
                        memReq <= 1'b1;
                        state <= Request;
                    end
                end
                Request: begin
                    if (memAck) begin
                        memReq <= 1'b0;
                        doneValid <= 1'b1;
                        occupied <= 1'b0; // the next request may be latched from here on.
                        state <= WaitRelease;
                    end
                end
                WaitRelease: begin
                    // a request latched meanwhile goes out once the controller lets go of ack.
                    if (!memAck) begin
                        if (occupied || transfer) begin
                            memReq <= 1'b1;
                            state <= Request;
                        end else begin
                            state <= Idle;
                        end
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (transfer) begin
            memStore <= issueStore;
            memAddr <= issueAddr;
            memWdata <= issueData;
            memLen <= issueLen;
            savedTag <= issueTag;
        end
        if (state == Request && memAck) begin
            doneData <= memStore ? '0 : memRdata; // stores complete with zero data.
            doneTag <= savedTag;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/loadStoreQueue.sv ====
`default_nettype none

module loadStoreQueue (
    input  logic               clk,
    input  logic               rst,

    input  logic               reqValid,
    input  logic               reqStore,
    input  lsuPkg::addr_t      reqAddr,
    input  lsuPkg::data_t      reqData,
    input  lsuPkg::accessLen_t reqLen,
    input  lsuPkg::tag_t       reqTag,
    output logic               reqReady,

    output logic               issueValid,
    output logic               issueStore,
    output lsuPkg::addr_t      issueAddr,
    output lsuPkg::data_t      issueData,
    output lsuPkg::accessLen_t issueLen,
    output lsuPkg::tag_t       issueTag,
    input  logic               portFree
);

    lsuPkg::queueEntry_t entries [lsuPkg::QueueDepth];

    logic [lsuPkg::QueuePtrBits-1:0] wrPtr;
    logic [lsuPkg::QueuePtrBits-1:0] rdPtr;
    logic [lsuPkg::QueueCountBits-1:0] count;

    logic push;
    logic pop;

    lsuPkg::queueEntry_t headWord;
    logic [1:0] headLen;

    function automatic logic [lsuPkg::QueuePtrBits-1:0] nextPtr(
        input logic [lsuPkg::QueuePtrBits-1:0] ptr
    );
        logic [lsuPkg::QueuePtrBits-1:0] next;
        if (ptr == lsuPkg::QueueDepth - 1) begin
            next = '0;
        end else begin
            next = ptr + 1'b1;
        end
        return next;
    endfunction

    assign reqReady = (count != lsuPkg::QueueDepth);
    assign issueValid = (count != '0);

    assign push = reqValid && reqReady;
    assign pop = issueValid && portFree;

    // the head entry is shown directly from the buffer.
    assign headWord = entries[rdPtr];
    assign {issueStore, issueAddr, issueData, headLen, issueTag} = headWord;
    assign issueLen = lsuPkg::accessLen_t'(headLen);

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither leave the fill level alone.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= {reqStore, reqAddr, reqData, reqLen, reqTag};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsuPkg.sv ====
`default_nettype none

package lsuPkg;

    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;
    localparam int TagWidth = 4;
    localparam int ByteWidth = 8;

    localparam int QueueDepth = 4;
    localparam int QueuePtrBits = $clog2(QueueDepth);
    localparam int QueueCountBits = $clog2(QueueDepth + 1);

    localparam int MemAddrBits = 10;
    localparam int MemBytes = 1 << MemAddrBits;

    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [DataWidth-1:0] data_t;
    typedef logic [TagWidth-1:0] tag_t;
    typedef logic [ByteWidth-1:0] memByte_t;
    typedef logic [MemAddrBits-1:0] memAddr_t;
    typedef logic [2:0] byteNum_t; // holds a byte count of one to four.

    typedef enum logic [1:0] {
        LenByte = 2'd0,
        LenHalf = 2'd1,
        LenWord = 2'd2
    } accessLen_t;

    // store flag, address, data, length and tag of one queued request.
    localparam int QueueEntryBits = 1 + AddrWidth + DataWidth + $bits(accessLen_t) + TagWidth;

    typedef logic [QueueEntryBits-1:0] queueEntry_t;

    function automatic byteNum_t byteCount(input accessLen_t len);
        byteNum_t num;
        case (len)
            LenByte: num = 3'd1;
            LenHalf: num = 3'd2;
            default: num = 3'd4; // an unused encoding is served as a word.
        endcase
        return num;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/lsuTop.sv ====
`default_nettype none

module lsuTop (
    input  logic               clk,
    input  logic               rst,

    input  logic               reqValid,
    input  logic               reqStore,
    input  lsuPkg::addr_t      reqAddr,
    input  lsuPkg::data_t      reqData,
    input  lsuPkg::accessLen_t reqLen,
    input  lsuPkg::tag_t       reqTag,
    output logic               reqReady,

    output logic               doneValid,
    output lsuPkg::data_t      doneData,
    output lsuPkg::tag_t       doneTag
);

    logic issueValid;
    logic issueStore;
    lsuPkg::addr_t issueAddr;
    lsuPkg::data_t issueData;
    lsuPkg::accessLen_t issueLen;
    lsuPkg::tag_t issueTag;
    logic portFree;

    logic memReq;
    logic memStore;
    lsuPkg::addr_t memAddr;
    lsuPkg::data_t memWdata;
    lsuPkg::accessLen_t memLen;
    logic memAck;
    lsuPkg::data_t memRdata;

    loadStoreQueue queue (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (reqValid),
        .reqStore   (reqStore),
        .reqAddr    (reqAddr),
        .reqData    (reqData),
        .reqLen     (reqLen),
        .reqTag     (reqTag),
        .reqReady   (reqReady),
        .issueValid (issueValid),
        .issueStore (issueStore),
        .issueAddr  (issueAddr),
        .issueData  (issueData),
        .issueLen   (issueLen),
        .issueTag   (issueTag),
        .portFree   (portFree)
    );

    dataAccessPort port (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid),
        .issueStore (issueStore),
        .issueAddr  (issueAddr),
        .issueData  (issueData),
        .issueLen   (issueLen),
        .issueTag   (issueTag),
        .portFree   (portFree),
        .memReq     (memReq),
        .memStore   (memStore),
        .memAddr    (memAddr),
        .memWdata   (memWdata),
        .memLen     (memLen),
        .memAck     (memAck),
        .memRdata   (memRdata),
        .doneValid  (doneValid),
        .doneData   (doneData),
        .doneTag    (doneTag)
    );

    memController ctrl (
        .clk      (clk),
        .rst      (rst),
        .memReq   (memReq),
        .memStore (memStore),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memLen   (memLen),
        .memAck   (memAck),
        .memRdata (memRdata)
    );

endmodule

`default_nettype wire

// ==== verilog/memController.sv ====
`default_nettype none

module memController (
    input  logic               clk,
    input  logic               rst,

    input  logic               memReq,
    input  logic               memStore,
    input  lsuPkg::addr_t      memAddr,
    input  lsuPkg::data_t      memWdata,
    input  lsuPkg::accessLen_t memLen,
    output logic               memAck,
    output lsuPkg::data_t      memRdata
);

    typedef enum logic [1:0] {
        Idle,
        Transfer,
        Acknowledge,
        Release
    } ctrlState_t;

    ctrlState_t state;

    lsuPkg::memByte_t ram [lsuPkg::MemBytes];

    lsuPkg::byteNum_t byteIdx;
    lsuPkg::byteNum_t lastIdx;
    lsuPkg::memAddr_t byteAddr;

    assign lastIdx = lsuPkg::byteCount(memLen) - 1'b1;

    // addresses past the top of the RAM wrap around.
    assign byteAddr = memAddr[lsuPkg::MemAddrBits-1:0] + lsuPkg::memAddr_t'(byteIdx);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            byteIdx <= '0;
            memAck <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (memReq) begin
                        byteIdx <= '0;
                        state <= Transfer;
                    end
                end
                Transfer: begin
                    if (byteIdx == lastIdx) begin
                        state <= Acknowledge;
                    end else begin
                        byteIdx <= byteIdx + 1'b1;
                    end
                end
                Acknowledge: begin
                    memAck <= 1'b1;
                    state <= Release;
                end
                Release: begin
                    // ack is held until the port has dropped its request.
                    if (!memReq) begin
                        memAck <= 1'b0;
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle && memReq) begin
            memRdata <= '0; // bytes above the access length stay zero.
        end else if (state == Transfer) begin
            if (memStore) begin
                ram[byteAddr] <= memWdata[8*byteIdx +: 8];
            end else begin
                memRdata[8*byteIdx +: 8] <= ram[byteAddr]; // little-endian assembly.
            end
        end
    end

endmodule

`default_nettype wire
